// File: source/rv_pkg.sv
// shared ISA constants, types and memory map for the RV32 subsystem
`default_nettype none

package rv_pkg;
    localparam int data_width    = 32;
    localparam int addr_width    = 32;
    localparam int num_regs      = 32;
    localparam int mem_words     = 256;
    localparam int mem_idx_width = $clog2(mem_words);

    typedef logic [data_width-1:0] data_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [4:0]            reg_sel_t;
    typedef logic [31:0]           instr_t;
    typedef logic [6:0]            opcode_t;

    // major opcodes
    localparam opcode_t op_opimm  = 7'b0010011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_op     = 7'b0110011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;

    localparam logic [2:0] f3_addi = 3'b000;
    localparam logic [2:0] f3_lw   = 3'b010;
    localparam logic [2:0] f3_sw   = 3'b010;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;

    // {funct7, funct3} for the register-register group
    localparam logic [9:0] fn_add  = 10'b0000000_000;
    localparam logic [9:0] fn_sub  = 10'b0100000_000;
    localparam logic [9:0] fn_sll  = 10'b0000000_001;
    localparam logic [9:0] fn_slt  = 10'b0000000_010;
    localparam logic [9:0] fn_sltu = 10'b0000000_011;
    localparam logic [9:0] fn_xor  = 10'b0000000_100;
    localparam logic [9:0] fn_srl  = 10'b0000000_101;
    localparam logic [9:0] fn_sra  = 10'b0100000_101;
    localparam logic [9:0] fn_or   = 10'b0000000_110;
    localparam logic [9:0] fn_and  = 10'b0000000_111;
    localparam logic [9:0] fn_mul  = 10'b0000001_000;

    // store targets that never reach memory
    localparam addr_t addr_out_int   = 32'd1000;
    localparam addr_t addr_halt      = 32'd1004;
    localparam addr_t addr_out_float = 32'd1008;

    typedef struct packed {
        opcode_t    op;
        logic [2:0] funct3;
        logic [9:0] op_funct;
        reg_sel_t   rd;
        reg_sel_t   rs1;
        reg_sel_t   rs2;
        data_t      imm_i;
        data_t      imm_s;
        data_t      imm_b;
        data_t      imm_u;
    } decoded_t;

    typedef struct packed {
        logic  rd_req;
        logic  wr_req;
        addr_t addr;
        data_t wr_data;
    } mem_req_t;

    typedef struct packed {
        logic  int_en;
        logic  float_en;
        logic  halt;
        data_t data;
    } out_req_t;

    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_mem_wait,
        st_halted
    } core_state_t;
endpackage

`default_nettype wire

// File: source/instr_decode.sv
// instruction decoder, splits a fetched RV32 word into fields and immediates
`default_nettype none
`timescale 1ns/1ps

module instr_decode (
    input  rv_pkg::instr_t   instr,
    output rv_pkg::decoded_t dec
);
    always_comb begin
        dec.op       = instr[6:0];
        dec.funct3   = instr[14:12];
        // funct7 above funct3, matches the fn_* codes
        dec.op_funct = {instr[31:25], instr[14:12]};
        dec.rd       = instr[11:7];
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];

        dec.imm_i = {{20{instr[31]}}, instr[31:20]};
        dec.imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        // branch offset is in units of two bytes, low bit is always zero
        dec.imm_b = {
            {19{instr[31]}},
            instr[31],
            instr[7],
            instr[30:25],
            instr[11:8],
            1'b0
        };
        dec.imm_u = {instr[31:12], 12'b0};
    end
endmodule

`default_nettype wire

// File: source/reg_file.sv
// integer register file, two combinational read ports and one write port
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_sel_t rs1,
    input  rv_pkg::reg_sel_t rs2,
    input  rv_pkg::reg_sel_t wr_sel,
    input  rv_pkg::data_t    wr_data,
    input  logic             wr_en,
    output rv_pkg::data_t    rs1_data,
    output rv_pkg::data_t    rs2_data
);
    rv_pkg::data_t regs [rv_pkg::num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rv_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_sel != '0)) begin
            // x0 is never written so it reads as zero
            regs[wr_sel] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];
endmodule

`default_nettype wire

// File: source/proc_core.sv
// multi-cycle RV32 core, fetch/execute/mem_wait FSM with ALU and branch logic
`default_nettype none
`timescale 1ns/1ps

module proc_core (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::data_t    rs1_data,
    input  rv_pkg::data_t    rs2_data,
    input  rv_pkg::data_t    mem_rd_data,
    input  logic             mem_ack,
    output rv_pkg::mem_req_t mem_req,
    output rv_pkg::reg_sel_t wr_sel,
    output rv_pkg::data_t    wr_data,
    output logic             wr_en,
    output rv_pkg::out_req_t out_req
);
    rv_pkg::core_state_t state;
    rv_pkg::core_state_t next_state;
    rv_pkg::addr_t       pc;
    rv_pkg::addr_t       next_pc;
    rv_pkg::reg_sel_t    pend_rd;
    rv_pkg::reg_sel_t    next_pend_rd;
    logic                pend_load;
    logic                next_pend_load;
    rv_pkg::data_t       alu_result;
    logic                alu_legal;
    rv_pkg::addr_t       ls_addr;
    logic                branch_taken;

    // register-register group
    always_comb begin
        alu_legal = 1'b1;
        case (dec.op_funct)
            rv_pkg::fn_add:  alu_result = rs1_data + rs2_data;
            rv_pkg::fn_sub:  alu_result = rs1_data - rs2_data;
            rv_pkg::fn_and:  alu_result = rs1_data & rs2_data;
            rv_pkg::fn_or:   alu_result = rs1_data | rs2_data;
            rv_pkg::fn_xor:  alu_result = rs1_data ^ rs2_data;
            rv_pkg::fn_sll:  alu_result = rs1_data << rs2_data[4:0];
            rv_pkg::fn_srl:  alu_result = rs1_data >> rs2_data[4:0];
            rv_pkg::fn_sra:  alu_result = $signed(rs1_data) >>> rs2_data[4:0];
            rv_pkg::fn_slt:  alu_result = {31'b0, $signed(rs1_data) < $signed(rs2_data)};
            rv_pkg::fn_sltu: alu_result = {31'b0, rs1_data < rs2_data};
            // low word of the product
            rv_pkg::fn_mul:  alu_result = rs1_data * rs2_data;
            default: begin
                alu_result = '0;
                alu_legal  = 1'b0;
            end
        endcase
    end

    assign ls_addr = rs1_data + ((dec.op == rv_pkg::op_store) ? dec.imm_s : dec.imm_i);
    assign branch_taken = (dec.funct3 == rv_pkg::f3_bne) ? (rs1_data != rs2_data)
                                                         : (rs1_data == rs2_data);

    always_comb begin
        next_state     = state;
        next_pc        = pc;
        next_pend_rd   = pend_rd;
        next_pend_load = pend_load;
        mem_req        = '0;
        wr_sel         = dec.rd;
        wr_data        = '0;
        wr_en          = 1'b0;
        out_req        = '0;

        case (state)
            rv_pkg::st_fetch: begin
                mem_req.rd_req = 1'b1;
                mem_req.addr   = pc;
                next_state     = rv_pkg::st_execute;
            end
            rv_pkg::st_execute: if (mem_ack) begin
                // instruction word is on mem_rd_data this cycle
                next_state = rv_pkg::st_fetch;
                next_pc    = pc + 32'd4;
                case (dec.op)
                    rv_pkg::op_opimm: begin
                        wr_en   = (dec.funct3 == rv_pkg::f3_addi);
                        wr_data = rs1_data + dec.imm_i;
                        out_req.halt = !wr_en;
                    end
                    rv_pkg::op_lui: begin
                        wr_en   = 1'b1;
                        wr_data = dec.imm_u;
                    end
                    rv_pkg::op_auipc: begin
                        wr_en   = 1'b1;
                        wr_data = pc + dec.imm_u;
                    end
                    rv_pkg::op_op: begin
                        wr_en   = alu_legal;
                        wr_data = alu_result;
                        out_req.halt = !alu_legal;
                    end
                    rv_pkg::op_branch: begin
                        if (dec.funct3 != rv_pkg::f3_beq && dec.funct3 != rv_pkg::f3_bne) begin
                            out_req.halt = 1'b1;
                        end else if (branch_taken) begin
                            next_pc = pc + dec.imm_b;
                        end
                    end
                    rv_pkg::op_load: begin
                        mem_req.rd_req = (dec.funct3 == rv_pkg::f3_lw);
                        mem_req.addr   = ls_addr;
                        next_pend_rd   = dec.rd;
                        next_pend_load = 1'b1;
                        next_state     = rv_pkg::st_mem_wait;
                        out_req.halt   = !mem_req.rd_req;
                    end
                    rv_pkg::op_store: begin
                        out_req.data = rs2_data;
                        if (dec.funct3 != rv_pkg::f3_sw) begin
                            out_req.halt = 1'b1;
                        end else begin
                            case (ls_addr)
                                rv_pkg::addr_out_int:   out_req.int_en   = 1'b1;
                                rv_pkg::addr_out_float: out_req.float_en = 1'b1;
                                rv_pkg::addr_halt:      out_req.halt     = 1'b1;
                                default: begin
                                    mem_req.wr_req  = 1'b1;
                                    mem_req.addr    = ls_addr;
                                    mem_req.wr_data = rs2_data;
                                    next_pend_load  = 1'b0;
                                    next_state      = rv_pkg::st_mem_wait;
                                end
                            endcase
                        end
                    end
                    default: out_req.halt = 1'b1;
                endcase
                // unknown opcode or function also stops the core
                if (out_req.halt) begin
                    next_state = rv_pkg::st_halted;
                end
            end
            rv_pkg::st_mem_wait: if (mem_ack) begin
                wr_en      = pend_load;
                wr_sel     = pend_rd;
                wr_data    = mem_rd_data;
                next_state = rv_pkg::st_fetch;
            end
            default: begin
                // halted until reset
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= rv_pkg::st_fetch;
            pc        <= '0;
            pend_rd   <= '0;
            pend_load <= 1'b0;
        end else begin
            state     <= next_state;
            pc        <= next_pc;
            pend_rd   <= next_pend_rd;
            pend_load <= next_pend_load;
        end
    end
endmodule

`default_nettype wire

// File: source/unified_mem.sv
// unified code and data word memory, one-cycle ack and a program-load port
`default_nettype none
`timescale 1ns/1ps

module unified_mem (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::mem_req_t req,
    input  logic             load_en,
    input  rv_pkg::addr_t    load_addr,
    input  rv_pkg::data_t    load_data,
    output rv_pkg::data_t    rd_data,
    output logic             ack
);
    rv_pkg::data_t mem_array [rv_pkg::mem_words];

    logic [rv_pkg::mem_idx_width-1:0] req_idx;
    logic [rv_pkg::mem_idx_width-1:0] load_idx;

    // byte address to word index
    assign req_idx  = req.addr[rv_pkg::mem_idx_width+1:2];
    // load port is already word indexed
    assign load_idx = load_addr[rv_pkg::mem_idx_width-1:0];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem_array[load_idx] <= load_data;
        end else if (req.wr_req) begin
            mem_array[req_idx] <= req.wr_data;
        end
        if (req.rd_req) begin
            rd_data <= mem_array[req_idx];
        end
    end

    // every request is answered on the next cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req.rd_req | req.wr_req;
        end
    end
endmodule

`default_nettype wire

// File: source/out_port.sv
// output port, registers the int/float strobes and data and holds the halt flag
`default_nettype none
`timescale 1ns/1ps

module out_port (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::out_req_t req,
    output rv_pkg::data_t    out_data,
    output logic             out_int_valid,
    output logic             out_float_valid,
    output logic             halted
);
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_int_valid   <= 1'b0;
            out_float_valid <= 1'b0;
            halted          <= 1'b0;
        end else begin
            out_int_valid   <= req.int_en;
            out_float_valid <= req.float_en;
            // sticky until reset
            if (req.halt) begin
                halted <= 1'b1;
            end
        end
    end

    // data stays put between strobes
    always_ff @(posedge clk) begin
        if (req.int_en || req.float_en) begin
            out_data <= req.data;
        end
    end
endmodule

`default_nettype wire

// File: source/rv_sys.sv
// RV32 subsystem top, joins memory, decoder, register file, core and output port
`default_nettype none
`timescale 1ns/1ps

module rv_sys (
    input  logic          clk,
    input  logic          rst,
    input  logic          load_en,
    input  rv_pkg::addr_t load_addr,
    input  rv_pkg::data_t load_data,
    output rv_pkg::data_t out_data,
    output logic          out_int_valid,
    output logic          out_float_valid,
    output logic          halted
);
    rv_pkg::mem_req_t mem_req;
    rv_pkg::data_t    mem_rd_data;
    logic             mem_ack;
    rv_pkg::decoded_t dec;
    rv_pkg::data_t    rs1_data;
    rv_pkg::data_t    rs2_data;
    rv_pkg::reg_sel_t wr_sel;
    rv_pkg::data_t    wr_data;
    logic             wr_en;
    rv_pkg::out_req_t out_req;

    unified_mem mem0 (
        .clk       (clk),
        .rst       (rst),
        .req       (mem_req),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_data   (mem_rd_data),
        .ack       (mem_ack)
    );

    instr_decode dec0 (
        .instr (mem_rd_data),
        .dec   (dec)
    );

    reg_file rf0 (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data),
        .wr_en    (wr_en),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    proc_core core0 (
        .clk         (clk),
        .rst         (rst),
        .dec         (dec),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .mem_req     (mem_req),
        .wr_sel      (wr_sel),
        .wr_data     (wr_data),
        .wr_en       (wr_en),
        .out_req     (out_req)
    );

    out_port out0 (
        .clk             (clk),
        .rst             (rst),
        .req             (out_req),
        .out_data        (out_data),
        .out_int_valid   (out_int_valid),
        .out_float_valid (out_float_valid),
        .halted          (halted)
    );
endmodule

`default_nettype wire

// File: tests/rv_sys_assert.sv
// protocol checks on memory requests, output strobes and the halt flag of rv_sys
`default_nettype none
`timescale 1ns/1ps

module rv_sys_assert (
    input logic                clk,
    input logic                rst,
    input rv_pkg::mem_req_t    mem_req,
    input logic                mem_ack,
    input rv_pkg::core_state_t state,
    input logic                out_int_valid,
    input logic                out_float_valid,
    input logic                halted
);
    // memory answers every request on the next cycle
    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        (mem_req.rd_req || mem_req.wr_req) |=> mem_ack)
        else $error("memory ack missing one cycle after a request");

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.rd_req || mem_req.wr_req) |=> !mem_ack)
        else $error("memory ack without a request in the cycle before");

    no_rd_wr_together: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.rd_req && mem_req.wr_req))
        else $error("read and write requested in the same cycle");

    strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(out_int_valid && out_float_valid))
        else $error("int and float output strobes high together");

    halted_sticky: assert property (@(posedge clk) disable iff (rst)
        halted |=> halted)
        else $error("halted fell without a reset");

    // core never waits more than one cycle for memory
    ack_in_wait_states: assert property (@(posedge clk) disable iff (rst)
        (state == rv_pkg::st_execute || state == rv_pkg::st_mem_wait) |-> mem_ack)
        else $error("core waited for memory without an ack");
endmodule

bind rv_sys rv_sys_assert chk0 (
    .clk             (clk),
    .rst             (rst),
    .mem_req         (mem_req),
    .mem_ack         (mem_ack),
    .state           (core0.state),
    .out_int_valid   (out_int_valid),
    .out_float_valid (out_float_valid),
    .halted          (halted)
);

`default_nettype wire

// File: tests/rv_sys_tb.sv
// testbench for rv_sys, random programs checked against an instruction-level model
`default_nettype none
`timescale 1ns/1ps

module rv_sys_tb;
    localparam int num_progs    = 8;
    localparam int max_instrs   = 45;
    localparam int min_body     = 40;
    localparam int quiet_cycles = 6;
    // reset, load and worst case of 3 cycles per instruction, per program
    localparam int cycle_limit  = num_progs * (8 + rv_pkg::mem_words + max_instrs * 3) + 200;

    logic          clk       = 1'b0;
    logic          rst       = 1'b1;
    logic          load_en   = 1'b0;
    rv_pkg::addr_t load_addr = '0;
    rv_pkg::data_t load_data = '0;
    rv_pkg::data_t out_data;
    logic          out_int_valid;
    logic          out_float_valid;
    logic          halted;

    logic [31:0]    rng           = 32'ha02e_1b8d;
    int             cycle_count   = 0;
    int             seen_count    = 0;
    int             exp_total     = 0;
    int             checks_failed = 0;
    rv_pkg::data_t  img  [rv_pkg::mem_words];
    rv_pkg::data_t  mimg [rv_pkg::mem_words];
    rv_pkg::instr_t prog [$];
    rv_pkg::data_t  exp_data [$];
    logic           exp_float [$];

    rv_sys dut0 (
        .clk             (clk),
        .rst             (rst),
        .load_en         (load_en),
        .load_addr       (load_addr),
        .load_data       (load_data),
        .out_data        (out_data),
        .out_int_valid   (out_int_valid),
        .out_float_valid (out_float_valid),
        .halted          (halted)
    );

    always #10 clk = ~clk;

    task automatic stop_with_error(input string msg);
        checks_failed++;
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_int_out(input rv_pkg::data_t got, input rv_pkg::data_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail out_data (int): got %08h, expected %08h", got, exp));
        end
    endtask

    task automatic check_float_out(input rv_pkg::data_t got, input rv_pkg::data_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail out_data (float): got %08h, expected %08h", got, exp));
        end
    endtask

    task automatic check_halt_count(input int got, input int exp);
        if (got != exp) begin
            stop_with_error($sformatf("Fail outputs before halted: got %0h, expected %0h", got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    // working registers are x1 to x7
    function automatic rv_pkg::reg_sel_t pick_reg();
        return rv_pkg::reg_sel_t'(1 + rand32() % 7);
    endfunction

    // word aligned, inside 512 to 959
    function automatic logic [11:0] pick_data_addr();
        return 12'(512 + 4 * (rand32() % 112));
    endfunction

    function automatic logic [9:0] pick_fn();
        case (rand32() % 11)
            0: return rv_pkg::fn_add;
            1: return rv_pkg::fn_sub;
            2: return rv_pkg::fn_and;
            3: return rv_pkg::fn_or;
            4: return rv_pkg::fn_xor;
            5: return rv_pkg::fn_sll;
            6: return rv_pkg::fn_srl;
            7: return rv_pkg::fn_sra;
            8: return rv_pkg::fn_slt;
            9: return rv_pkg::fn_sltu;
            default: return rv_pkg::fn_mul;
        endcase
    endfunction

    function automatic rv_pkg::instr_t enc_r(input logic [9:0] fn, input rv_pkg::reg_sel_t rd,
                                             input rv_pkg::reg_sel_t rs1,
                                             input rv_pkg::reg_sel_t rs2);
        return {fn[9:3], rs2, rs1, fn[2:0], rd, rv_pkg::op_op};
    endfunction

    function automatic rv_pkg::instr_t enc_i(input logic [11:0] imm, input rv_pkg::reg_sel_t rs1,
                                             input logic [2:0] f3, input rv_pkg::reg_sel_t rd,
                                             input rv_pkg::opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::instr_t enc_s(input logic [11:0] imm, input rv_pkg::reg_sel_t rs2,
                                             input rv_pkg::reg_sel_t rs1);
        return {imm[11:5], rs2, rs1, rv_pkg::f3_sw, imm[4:0], rv_pkg::op_store};
    endfunction

    function automatic rv_pkg::instr_t enc_b(input logic [12:0] imm, input rv_pkg::reg_sel_t rs1,
                                             input rv_pkg::reg_sel_t rs2, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
    endfunction

    function automatic rv_pkg::instr_t enc_u(input logic [19:0] imm, input rv_pkg::reg_sel_t rd,
                                             input rv_pkg::opcode_t op);
        return {imm, rd, op};
    endfunction

    // ISA results for the register-register group
    function automatic rv_pkg::data_t alu_model(input logic [9:0] fn, input rv_pkg::data_t a,
                                                input rv_pkg::data_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (fn)
            rv_pkg::fn_add:  return a + b;
            rv_pkg::fn_sub:  return a - b;
            rv_pkg::fn_and:  return a & b;
            rv_pkg::fn_or:   return a | b;
            rv_pkg::fn_xor:  return a ^ b;
            rv_pkg::fn_sll:  return a << sh;
            rv_pkg::fn_srl:  return a >> sh;
            // fill the vacated top bits with the sign
            rv_pkg::fn_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            rv_pkg::fn_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            rv_pkg::fn_sltu: return {31'b0, a < b};
            rv_pkg::fn_mul:  return a * b;
            default:         return 32'h0;
        endcase
    endfunction

    task automatic emit_out(input rv_pkg::reg_sel_t r);
        logic [31:0] x;
        x = rand32();
        prog.push_back(enc_s(x[0] ? 12'd1008 : 12'd1000, r, 5'd0));
    endtask

    task automatic gen_program();
        logic [31:0]      r;
        rv_pkg::reg_sel_t rd;
        rv_pkg::reg_sel_t rs1;
        rv_pkg::reg_sel_t rs2;
        logic [11:0]      a;
        int               skip;
        prog.delete();
        for (int i = 1; i < 8; i++) begin
            r = rand32();
            prog.push_back(enc_u(r[31:12], rv_pkg::reg_sel_t'(i), rv_pkg::op_lui));
            prog.push_back(enc_i(r[11:0], rv_pkg::reg_sel_t'(i), rv_pkg::f3_addi,
                                 rv_pkg::reg_sel_t'(i), rv_pkg::op_opimm));
        end
        r  = rand32();
        rd = pick_reg();
        prog.push_back(enc_u(r[31:12], rd, rv_pkg::op_auipc));
        prog.push_back(enc_s(12'd1000, rd, 5'd0));
        while (prog.size() < min_body) begin
            r   = rand32();
            rd  = pick_reg();
            rs1 = pick_reg();
            // equal operands now and then, so BEQ gets taken too
            rs2 = (r[9:8] == 2'b00) ? rs1 : pick_reg();
            case (r[2:0])
                3'd0: prog.push_back(enc_u(r[31:12], rd, rv_pkg::op_lui));
                3'd1: prog.push_back(enc_i(r[31:20], rs1, rv_pkg::f3_addi, rd, rv_pkg::op_opimm));
                3'd2, 3'd3: prog.push_back(enc_r(pick_fn(), rd, rs1, rs2));
                3'd4: begin
                    a = pick_data_addr();
                    prog.push_back(enc_s(a, rs2, 5'd0));
                    // same word, another word, or a mapped address
                    case (r[11:10])
                        2'd0: a = pick_data_addr();
                        2'd1: a = r[12] ? 12'd1008 : 12'd1000;
                        default: a = a;
                    endcase
                    prog.push_back(enc_i(a, 5'd0, rv_pkg::f3_lw, rd, rv_pkg::op_load));
                end
                3'd5: begin
                    skip = int'(r[13:12]) + 1;
                    prog.push_back(enc_b(13'((skip + 1) * 4), rs1, rs2,
                                         r[14] ? rv_pkg::f3_bne : rv_pkg::f3_beq));
                    for (int k = 0; k < skip; k++) begin
                        emit_out(pick_reg());
                    end
                end
                3'd6: prog.push_back(enc_u(r[31:12], rd, rv_pkg::op_auipc));
                default: emit_out(rs1);
            endcase
            if (r[2:0] != 3'd5 && r[2:0] != 3'd7) begin
                emit_out(rd);
            end
        end
        prog.push_back(enc_s(12'd1004, pick_reg(), 5'd0));
    endtask

    task automatic build_image();
        for (int i = 0; i < rv_pkg::mem_words; i++) begin
            img[i] = {8'hc3, 8'(i), ~8'(i), 8'(i) ^ 8'h5a};
        end
        for (int i = 0; i < prog.size(); i++) begin
            img[i] = prog[i];
        end
        mimg = img;
    endtask

    // steps through the image word by word and queues the expected outputs
    task automatic run_model();
        rv_pkg::data_t  xr [32];
        rv_pkg::addr_t  pc;
        rv_pkg::addr_t  npc;
        rv_pkg::addr_t  ea;
        rv_pkg::instr_t w;
        rv_pkg::data_t  a;
        rv_pkg::data_t  b;
        rv_pkg::data_t  imm_i;
        rv_pkg::data_t  imm_s;
        rv_pkg::data_t  imm_b;
        rv_pkg::data_t  res;
        logic           wr;
        logic           done;
        int             steps;
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        exp_data.delete();
        exp_float.delete();
        while (!done) begin
            if (steps > max_instrs) begin
                stop_with_error("the reference model ran past the end of the program");
            end
            w     = mimg[pc[9:2]];
            a     = xr[w[19:15]];
            b     = xr[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            npc   = pc + 32'd4;
            wr    = 1'b1;
            res   = '0;
            case (w[6:0])
                rv_pkg::op_lui:   res = {w[31:12], 12'h0};
                rv_pkg::op_auipc: res = pc + {w[31:12], 12'h0};
                rv_pkg::op_opimm: res = a + imm_i;
                rv_pkg::op_op:    res = alu_model({w[31:25], w[14:12]}, a, b);
                rv_pkg::op_load: begin
                    ea  = a + imm_i;
                    res = mimg[ea[9:2]];
                end
                rv_pkg::op_branch: begin
                    wr = 1'b0;
                    if ((w[14:12] == rv_pkg::f3_bne) ? (a != b) : (a == b)) begin
                        npc = pc + imm_b;
                    end
                end
                rv_pkg::op_store: begin
                    wr = 1'b0;
                    ea = a + imm_s;
                    if (ea == rv_pkg::addr_out_int || ea == rv_pkg::addr_out_float) begin
                        exp_data.push_back(b);
                        exp_float.push_back(ea == rv_pkg::addr_out_float);
                    end else if (ea == rv_pkg::addr_halt) begin
                        done = 1'b1;
                    end else begin
                        mimg[ea[9:2]] = b;
                    end
                end
                default: stop_with_error("the generated program holds an unknown opcode");
            endcase
            if (wr && w[11:7] != 5'd0) begin
                xr[w[11:7]] = res;
            end
            pc = npc;
            steps++;
        end
    endtask

    // outputs are sampled away from the driving edge
    always @(negedge clk) begin
        if (!rst && (out_int_valid || out_float_valid)) begin
            if (exp_data.size() == 0) begin
                stop_with_error("an output strobe came that the model does not expect");
            end else if (exp_float[0] != out_float_valid) begin
                stop_with_error("an output came on the wrong strobe");
            end else begin
                if (out_float_valid) begin
                    check_float_out(out_data, exp_data[0]);
                end else begin
                    check_int_out(out_data, exp_data[0]);
                end
                void'(exp_data.pop_front());
                void'(exp_float.pop_front());
                seen_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            stop_with_error("timeout, the run took more cycles than the tests allow");
        end
    end

    initial begin
        for (int p = 0; p < num_progs; p++) begin
            gen_program();
            build_image();
            run_model();
            @(posedge clk);
            rst <= 1'b1;
            repeat (4) @(posedge clk);
            // program goes in while the core is held in reset
            for (int i = 0; i < rv_pkg::mem_words; i++) begin
                load_en   <= 1'b1;
                load_addr <= rv_pkg::addr_t'(i);
                load_data <= img[i];
                @(posedge clk);
            end
            load_en    <= 1'b0;
            seen_count = 0;
            exp_total  = exp_data.size();
            rst        <= 1'b0;
            @(negedge clk);
            while (!halted) begin
                @(negedge clk);
            end
            repeat (quiet_cycles) begin
                @(negedge clk);
                if (!halted) begin
                    stop_with_error("halted fell without a reset");
                end
            end
            check_halt_count(seen_count, exp_total);
        end
        if (checks_failed == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "checks failed");
        end
    end
endmodule

`default_nettype wire

// File: rv_sys.f
source/rv_pkg.sv
source/instr_decode.sv
source/reg_file.sv
source/proc_core.sv
source/unified_mem.sv
source/out_port.sv
source/rv_sys.sv
tests/rv_sys_assert.sv
tests/rv_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the rv_sys testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module rv_sys_tb \
    -f rv_sys.f

# exit status of the simulation is the result
./obj_dir/Vrv_sys_tb
